// ==== list.f ====
rtl/lsu_dccm_pkg.sv
rtl/lsu_stage_if.sv
rtl/lsu_pipe_regs.sv
rtl/ecc_corr_regs.sv
rtl/dccm_port_arb.sv
rtl/load_data_merge.sv
rtl/pic_access.sv
rtl/lsu_dccm_ctl.sv
tb/lsu_dccm_assert.sv
tb/lsu_dccm_checker.sv
tb/tb_lsu_dccm_ctl.sv

// ==== Bender.yml ====
package:
  name: lsu_dccm_ctl

sources:
  - rtl/lsu_dccm_pkg.sv
  - rtl/lsu_stage_if.sv
  - rtl/lsu_pipe_regs.sv
  - rtl/ecc_corr_regs.sv
  - rtl/dccm_port_arb.sv
  - rtl/load_data_merge.sv
  - rtl/pic_access.sv
  - rtl/lsu_dccm_ctl.sv
  - target: simulation
    files:
      - tb/lsu_dccm_assert.sv
      - tb/lsu_dccm_checker.sv
      - tb/tb_lsu_dccm_ctl.sv

// ==== tb/tb_lsu_dccm_ctl.sv ====
// seeded random run of 2000 cycles; DMA DCCM writes are held off in write-back cycles
`timescale 1ns/1ps

module tb_lsu_dccm_ctl;

   localparam int NUM_CYCLES = 2000;
   localparam int CLK_PERIOD = 20;

   logic clk, rst, d_valid, d_load, d_store, d_dma, commit_r, stbuf_req, stbuf_commit;
   logic double_ecc_error_m, single_ecc_error_r, double_ecc_error_r, raw_fwd_r;
   logic ld_single_ecc_error_r, ld_valid_r, dma_dccm_wen, dma_pic_wen, dma_rvalid;
   logic dma_ecc_error, dccm_rden, dccm_wren, picm_rden, picm_mken, picm_wren;
   lsu_dccm_pkg::size_t      d_size;
   lsu_dccm_pkg::addr_t      d_addr, dma_addr, picm_rdaddr, picm_wraddr;
   lsu_dccm_pkg::data_t      store_data_m, stbuf_data, stbuf_fwddata_m, sec_data_m, sec_data_r;
   lsu_dccm_pkg::data_t      ld_data_m, ld_data_r, dma_wdata, dma_rdata, picm_wr_data;
   lsu_dccm_pkg::data_t      picm_rd_data;
   lsu_dccm_pkg::ecc_t       stbuf_ecc, sec_ecc_r, dma_wecc;
   lsu_dccm_pkg::dccm_addr_t stbuf_addr, dccm_rd_addr, dccm_wr_addr;
   lsu_dccm_pkg::byteen_t    stbuf_fwdbyteen_m;
   lsu_dccm_pkg::dma_tag_t   dma_tag_m, dma_rtag;
   lsu_dccm_pkg::fdata_t     dccm_rd_data, dccm_wr_data;
   int unsigned              err_count;

   integer seed = 71;

   lsu_dccm_pkg::fdata_t dccm_mem [0:1023];                 // one word per DCCM word address
   lsu_dccm_pkg::data_t  pic_regs [0:8191];                 // whole 15-bit PIC window

   lsu_dccm_ctl     lsu_dccm_ctl_inst (.*);
   lsu_dccm_checker lsu_dccm_checker_inst (.*);

   bind lsu_dccm_ctl lsu_dccm_assert lsu_dccm_assert_inst (
      .clk, .rst, .wb_pending (ecc_wb.pending), .r_dma (stage_r.dma), .commit_r,
      .ld_single_ecc_error_r, .stbuf_commit, .dccm_wren, .dccm_rden, .picm_rden
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      for (int i = 0; i < 1024; i++) begin
         dccm_mem[i] = {7'(i), 32'(i) * 32'h9E37_79B9};
      end
      for (int i = 0; i < 8192; i++) begin
         pic_regs[i] = (32'(i) * 32'h85EB_CA6B) ^ 32'hC001_0000;
      end
      dccm_rd_data = '0;
      picm_rd_data = '0;
   end

   // DCCM and PIC both return read data one cycle after the strobe
   always @(posedge clk) begin
      if (dccm_rden) dccm_rd_data <= dccm_mem[dccm_rd_addr[11:2]];
      if (dccm_wren) dccm_mem[dccm_wr_addr[11:2]] <= dccm_wr_data;
      if (picm_rden) picm_rd_data <= pic_regs[picm_rdaddr[14:2]];
      if (picm_wren) pic_regs[picm_wraddr[14:2]] <= picm_wr_data;
   end

   task automatic drive_inputs(input bit en);
      logic [31:0]         op;
      lsu_dccm_pkg::addr_t addr;
      op = $random(seed);
      case (op[5:3])                                        // mostly DCCM, some PIC, a few elsewhere
         3'd5, 3'd6: addr = 32'hF00C_0000 | ($random(seed) & 32'h7FFF);
         3'd7:       addr = $random(seed);
         default:    addr = 32'hF004_0000 | ($random(seed) & 32'hFFF);
      endcase
      d_valid            <= en & (op[7:6] != 2'b00);
      d_load             <= op[0];
      d_store            <= ~op[0];
      d_dma              <= op[2:1] == 2'b00;
      d_size             <= lsu_dccm_pkg::size_t'(op[9:8] % 3);
      d_addr             <= addr;
      store_data_m       <= $random(seed);
      commit_r           <= op[11:10] != 2'b00;
      single_ecc_error_r <= op[13:12] == 2'b00;
      double_ecc_error_r <= op[16:14] == 3'b000;
      raw_fwd_r          <= op[19:17] == 3'b000;
      double_ecc_error_m <= op[20];
      stbuf_fwdbyteen_m  <= op[24:21] & op[28:25];         // sparse forwarding
      stbuf_fwddata_m    <= $random(seed);
      sec_data_m         <= $random(seed);
      sec_data_r         <= $random(seed);
      sec_ecc_r          <= lsu_dccm_pkg::ecc_t'($random(seed));
      dma_tag_m          <= op[31:29];
      op = $random(seed);
      // a load error this cycle may turn into a write-back next cycle
      dma_dccm_wen       <= en & (op[2:0] == 3'b000) & ~ld_single_ecc_error_r;
      dma_pic_wen        <= en & (op[5:3] == 3'b000);
      dma_addr           <= 32'hF00C_0000 | ($random(seed) & 32'h7FFF);
      dma_wdata          <= $random(seed);
      dma_wecc           <= lsu_dccm_pkg::ecc_t'($random(seed));
      if (!stbuf_req || stbuf_commit) begin                 // entry holds until committed
         stbuf_req  <= en & op[6];
         stbuf_addr <= lsu_dccm_pkg::dccm_addr_t'($random(seed));
         stbuf_data <= $random(seed);
         stbuf_ecc  <= lsu_dccm_pkg::ecc_t'($random(seed));
      end
   endtask

   initial begin
      int unsigned assert_errors;
      rst       = 1'b1;
      stbuf_req = 1'b0;
      drive_inputs(1'b0);
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      repeat (NUM_CYCLES) begin
         @(posedge clk);
         drive_inputs(1'b1);
      end
      repeat (2) @(posedge clk);
      #5;
      assert_errors = lsu_dccm_ctl_inst.lsu_dccm_assert_inst.fail_count;
      $display("check errors: %0d, assertion errors: %0d", err_count, assert_errors);
      if (err_count == 0 && assert_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      #((NUM_CYCLES + 60) * CLK_PERIOD);
      $display("error: the run did not end within %0d cycles", NUM_CYCLES + 60);
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== tb/lsu_dccm_checker.sv ====
// reference model sampled on the falling edge; expects inputs to change only at the rising edge
`timescale 1ns/1ps

module lsu_dccm_checker (
   input  logic                     clk, rst, d_valid, d_load, d_store, d_dma, commit_r,
   input  logic                     stbuf_req, stbuf_commit, double_ecc_error_m,
   input  logic                     single_ecc_error_r, double_ecc_error_r, raw_fwd_r,
   input  logic                     ld_single_ecc_error_r, ld_valid_r, dma_dccm_wen,
   input  logic                     dma_pic_wen, dma_rvalid, dma_ecc_error, dccm_rden,
   input  logic                     dccm_wren, picm_rden, picm_mken, picm_wren,
   input  lsu_dccm_pkg::size_t      d_size,
   input  lsu_dccm_pkg::addr_t      d_addr, dma_addr, picm_rdaddr, picm_wraddr,
   input  lsu_dccm_pkg::data_t      store_data_m, stbuf_data, stbuf_fwddata_m, sec_data_m,
   input  lsu_dccm_pkg::data_t      sec_data_r, ld_data_m, ld_data_r, dma_wdata, dma_rdata,
   input  lsu_dccm_pkg::data_t      picm_wr_data, picm_rd_data,
   input  lsu_dccm_pkg::ecc_t       stbuf_ecc, sec_ecc_r, dma_wecc,
   input  lsu_dccm_pkg::dccm_addr_t stbuf_addr, dccm_rd_addr, dccm_wr_addr,
   input  lsu_dccm_pkg::byteen_t    stbuf_fwdbyteen_m,
   input  lsu_dccm_pkg::dma_tag_t   dma_tag_m, dma_rtag,
   input  lsu_dccm_pkg::fdata_t     dccm_rd_data, dccm_wr_data,
   output int unsigned              err_count
);

   typedef struct packed {
      logic                valid;
      logic                load;
      logic                store;
      logic                dma;
      lsu_dccm_pkg::addr_t addr;
      lsu_dccm_pkg::data_t sdata;                           // store data seen in M
      lsu_dccm_pkg::data_t corr;                            // justified corrected load data
   } pkt_t;

   pkt_t                     m_pkt, r_pkt;
   logic                     wb_pend;
   lsu_dccm_pkg::dccm_addr_t wb_addr;
   lsu_dccm_pkg::data_t      wb_data;
   lsu_dccm_pkg::ecc_t       wb_ecc;

   initial err_count = 0;

   function automatic logic in_dccm_region(input lsu_dccm_pkg::addr_t a);
      return a[31:12] == 20'hF0040;                         // 4 KiB window at 0xF004_0000
   endfunction

   function automatic logic in_pic_region(input lsu_dccm_pkg::addr_t a);
      return a[31:15] == 17'h1E018;                         // 32 KiB window at 0xF00C_0000
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   always @(negedge clk) begin
      logic                     rden, commit, wren, p_rd, p_mk, p_wr, sec, ld_r, dma_rd;
      lsu_dccm_pkg::data_t      fmask, src_raw, src_corr, raw_w, corr_w;
      lsu_dccm_pkg::dccm_addr_t wa;
      lsu_dccm_pkg::fdata_t     wd;
      if (rst) begin
         m_pkt   = '0;
         r_pkt   = '0;
         wb_pend = 1'b0;
      end else begin
         // D stage reads and the write port
         rden = d_valid & in_dccm_region(d_addr) &
                (d_load | (d_store & ((d_size != 2'b10) | (d_addr[1:0] != 2'b00))));
         compare_value("dccm_rden", dccm_rden, rden);
         if (rden) compare_value("dccm_rd_addr", dccm_rd_addr, d_addr[11:0]);
         p_rd = d_valid & d_load & in_pic_region(d_addr);
         p_mk = d_valid & d_store & in_pic_region(d_addr);
         compare_value("picm_rden", picm_rden, p_rd);
         compare_value("picm_mken", picm_mken, p_mk);
         if (p_rd | p_mk) compare_value("picm_rdaddr", picm_rdaddr, 32'hF00C_0000 | d_addr[14:0]);
         commit = stbuf_req & ~dma_dccm_wen & ~wb_pend &
                  ~(rden & (d_addr[3:2] == stbuf_addr[3:2]));
         wren   = wb_pend | dma_dccm_wen | commit;
         compare_value("stbuf_commit", stbuf_commit, commit);
         compare_value("dccm_wren", dccm_wren, wren);
         if (wb_pend) begin
            wa = wb_addr;
            wd = {wb_ecc, wb_data};
         end else if (dma_dccm_wen) begin
            wa = d_addr[11:0];
            wd = {dma_wecc, dma_wdata};
         end else begin
            wa = stbuf_addr;
            wd = {stbuf_ecc, stbuf_data};
         end
         if (wren) compare_value("dccm_wr_addr", dccm_wr_addr, wa);
         if (wren) compare_value("dccm_wr_data", dccm_wr_data, wd);

         // M stage merge takes forwarded bytes first, then PIC, then DCCM
         fmask    = {{8{stbuf_fwdbyteen_m[3]}}, {8{stbuf_fwdbyteen_m[2]}},
                     {8{stbuf_fwdbyteen_m[1]}}, {8{stbuf_fwdbyteen_m[0]}}};
         src_raw  = in_pic_region(m_pkt.addr) ? picm_rd_data :
                    (in_dccm_region(m_pkt.addr) ? dccm_rd_data[31:0] : '0);
         src_corr = in_pic_region(m_pkt.addr) ? picm_rd_data :
                    (in_dccm_region(m_pkt.addr) ? sec_data_m : '0);
         raw_w    = (stbuf_fwddata_m & fmask) | (src_raw & ~fmask);
         corr_w   = (stbuf_fwddata_m & fmask) | (src_corr & ~fmask);
         if (m_pkt.valid & m_pkt.load) begin
            compare_value("ld_data_m", ld_data_m, raw_w >> (8 * m_pkt.addr[1:0]));
         end
         m_pkt.corr = corr_w >> (8 * m_pkt.addr[1:0]);
         dma_rd = m_pkt.valid & m_pkt.load & m_pkt.dma;
         compare_value("dma_rvalid", dma_rvalid, dma_rd);
         if (dma_rd) begin
            compare_value("dma_rtag", dma_rtag, dma_tag_m);
            compare_value("dma_rdata", dma_rdata, corr_w);     // whole word without the shift
            compare_value("dma_ecc_error", dma_ecc_error, double_ecc_error_m);
         end

         // R stage load result, ECC capture and PIC write
         ld_r = r_pkt.valid & r_pkt.load &
                (in_pic_region(r_pkt.addr) | in_dccm_region(r_pkt.addr));
         compare_value("ld_valid_r", ld_valid_r, ld_r);
         if (ld_r) compare_value("ld_data_r", ld_data_r, r_pkt.corr);
         sec = r_pkt.valid & r_pkt.load & single_ecc_error_r & ~raw_fwd_r & ~double_ecc_error_r;
         compare_value("ld_single_ecc_error_r", ld_single_ecc_error_r, sec);
         p_wr = (r_pkt.valid & r_pkt.store & in_pic_region(r_pkt.addr) & commit_r) | dma_pic_wen;
         compare_value("picm_wren", picm_wren, p_wr);
         if (p_wr) begin
            compare_value("picm_wraddr", picm_wraddr,
                          32'hF00C_0000 | (dma_pic_wen ? dma_addr[14:0] : r_pkt.addr[14:0]));
            compare_value("picm_wr_data", picm_wr_data, dma_pic_wen ? dma_wdata : r_pkt.sdata);
         end
         wb_pend = sec & (commit_r | r_pkt.dma);               // written back next cycle
         if (sec) begin
            wb_addr = r_pkt.addr[11:0];
            wb_data = sec_data_r;
            wb_ecc  = sec_ecc_r;
         end

         m_pkt.sdata = store_data_m;
         r_pkt       = m_pkt;
         m_pkt       = '{valid: d_valid, load: d_load, store: d_store, dma: d_dma,
                         addr: d_addr, sdata: '0, corr: '0};
      end
   end

endmodule

// ==== tb/lsu_dccm_assert.sv ====
// bound into the controller top; the write-back and R-stage DMA bits come in through the bind
`timescale 1ns/1ps

module lsu_dccm_assert (
   input logic clk, rst, wb_pending, r_dma, commit_r, ld_single_ecc_error_r,
   input logic stbuf_commit, dccm_wren, dccm_rden, picm_rden
);

   int unsigned fail_count = 0;                             // read by the testbench top

   wb_has_source: assert property (@(posedge clk) disable iff (rst)
      wb_pending |-> $past(ld_single_ecc_error_r & (commit_r | r_dma)))
      else begin
         $error("ECC write-back without a committed or DMA load error the cycle before");
         fail_count++;
      end

   commit_writes: assert property (@(posedge clk) disable iff (rst) stbuf_commit |-> dccm_wren)
      else begin
         $error("store buffer commit without a DCCM write enable");
         fail_count++;
      end

   one_read_region: assert property (@(posedge clk) disable iff (rst) !(picm_rden && dccm_rden))
      else begin
         $error("PIC and DCCM read strobes high in the same cycle");
         fail_count++;
      end

endmodule

// ==== rtl/lsu_dccm_ctl.sv ====
// DCCM/PIC port controller top; ECC decode is external and load data is final in M
`timescale 1ns/1ps

module lsu_dccm_ctl (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     d_valid,
   input  logic                     d_load,
   input  logic                     d_store,
   input  logic                     d_dma,
   input  lsu_dccm_pkg::size_t      d_size,
   input  lsu_dccm_pkg::addr_t      d_addr,
   input  lsu_dccm_pkg::data_t      store_data_m,
   input  logic                     commit_r,
   input  logic                     stbuf_req,
   input  lsu_dccm_pkg::dccm_addr_t stbuf_addr,
   input  lsu_dccm_pkg::data_t      stbuf_data,
   input  lsu_dccm_pkg::ecc_t       stbuf_ecc,
   input  lsu_dccm_pkg::data_t      stbuf_fwddata_m,
   input  lsu_dccm_pkg::byteen_t    stbuf_fwdbyteen_m,
   output logic                     stbuf_commit,
   input  lsu_dccm_pkg::data_t      sec_data_m,
   input  logic                     double_ecc_error_m,
   input  logic                     single_ecc_error_r,
   input  logic                     double_ecc_error_r,
   input  logic                     raw_fwd_r,
   input  lsu_dccm_pkg::data_t      sec_data_r,
   input  lsu_dccm_pkg::ecc_t       sec_ecc_r,
   output logic                     ld_single_ecc_error_r,
   output lsu_dccm_pkg::data_t      ld_data_m,
   output lsu_dccm_pkg::data_t      ld_data_r,
   output logic                     ld_valid_r,
   input  logic                     dma_dccm_wen,
   input  logic                     dma_pic_wen,
   input  lsu_dccm_pkg::addr_t      dma_addr,
   input  lsu_dccm_pkg::data_t      dma_wdata,
   input  lsu_dccm_pkg::ecc_t       dma_wecc,
   input  lsu_dccm_pkg::dma_tag_t   dma_tag_m,
   output logic                     dma_rvalid,
   output logic                     dma_ecc_error,
   output lsu_dccm_pkg::dma_tag_t   dma_rtag,
   output lsu_dccm_pkg::data_t      dma_rdata,
   output logic                     dccm_rden,
   output logic                     dccm_wren,
   output lsu_dccm_pkg::dccm_addr_t dccm_rd_addr,
   output lsu_dccm_pkg::dccm_addr_t dccm_wr_addr,
   output lsu_dccm_pkg::fdata_t     dccm_wr_data,
   input  lsu_dccm_pkg::fdata_t     dccm_rd_data,           // valid in M
   output logic                     picm_rden,
   output logic                     picm_mken,
   output logic                     picm_wren,
   output lsu_dccm_pkg::addr_t      picm_rdaddr,
   output lsu_dccm_pkg::addr_t      picm_wraddr,
   output lsu_dccm_pkg::data_t      picm_wr_data,
   input  lsu_dccm_pkg::data_t      picm_rd_data
);

   lsu_dccm_pkg::data_t store_data_r;

   lsu_stage_if stage_d ();
   lsu_stage_if stage_m ();
   lsu_stage_if stage_r ();
   ecc_wb_if    ecc_wb ();

   lsu_pipe_regs lsu_pipe_regs_inst (
      .clk, .rst, .d_valid, .d_load, .d_store, .d_dma, .d_size, .d_addr,
      .store_data_m, .store_data_r,
      .stage_d (stage_d.src), .stage_m (stage_m.src), .stage_r (stage_r.src)
   );

   ecc_corr_regs ecc_corr_regs_inst (
      .clk, .rst, .stage_r (stage_r.dst), .commit_r, .single_ecc_error_r,
      .double_ecc_error_r, .raw_fwd_r, .sec_data_r, .sec_ecc_r,
      .ld_single_ecc_error_r, .wb (ecc_wb.src)
   );

   dccm_port_arb dccm_port_arb_inst (
      .stage_d (stage_d.dst), .wb (ecc_wb.dst), .dma_dccm_wen, .stbuf_req,
      .dma_wdata, .dma_wecc, .stbuf_addr, .stbuf_data, .stbuf_ecc,
      .stbuf_commit, .dccm_rden, .dccm_wren, .dccm_rd_addr, .dccm_wr_addr, .dccm_wr_data
   );

   load_data_merge load_data_merge_inst (
      .clk, .rst, .stage_m (stage_m.dst), .dccm_rd_data, .sec_data_m,
      .stbuf_fwddata_m, .stbuf_fwdbyteen_m, .picm_rd_data, .double_ecc_error_m, .dma_tag_m,
      .ld_data_m, .ld_data_r, .ld_valid_r,
      .dma_rvalid, .dma_ecc_error, .dma_rtag, .dma_rdata
   );

   pic_access pic_access_inst (
      .stage_d (stage_d.dst), .stage_r (stage_r.dst), .commit_r, .dma_pic_wen,
      .dma_addr, .dma_wdata, .store_data_r,
      .picm_rden, .picm_mken, .picm_wren, .picm_rdaddr, .picm_wraddr, .picm_wr_data
   );

endmodule

// ==== rtl/pic_access.sv ====
// PIC strobes and addresses; PIC registers are 32-bit, low address bits pass through unchanged
`timescale 1ns/1ps

module pic_access (
   lsu_stage_if.dst            stage_d,
   lsu_stage_if.dst            stage_r,
   input  logic                commit_r,
   input  logic                dma_pic_wen,
   input  lsu_dccm_pkg::addr_t dma_addr,
   input  lsu_dccm_pkg::data_t dma_wdata,
   input  lsu_dccm_pkg::data_t store_data_r,
   output logic                picm_rden,
   output logic                picm_mken,
   output logic                picm_wren,
   output lsu_dccm_pkg::addr_t picm_rdaddr,
   output lsu_dccm_pkg::addr_t picm_wraddr,
   output lsu_dccm_pkg::data_t picm_wr_data
);

   logic [lsu_dccm_pkg::PIC_BITS-1:0] wr_offset;

   assign picm_rden = stage_d.valid & stage_d.load  & stage_d.in_pic;
   assign picm_mken = stage_d.valid & stage_d.store & stage_d.in_pic;   // stores fetch the mask
   assign picm_wren = (stage_r.valid & stage_r.store & stage_r.in_pic & commit_r) | dma_pic_wen;

   assign picm_rdaddr = lsu_dccm_pkg::PIC_BASE |
                        lsu_dccm_pkg::addr_t'(stage_d.addr[lsu_dccm_pkg::PIC_BITS-1:0]);

   // DMA takes the write port over a committing store
   assign wr_offset    = dma_pic_wen ? dma_addr[lsu_dccm_pkg::PIC_BITS-1:0] :
                                       stage_r.addr[lsu_dccm_pkg::PIC_BITS-1:0];
   assign picm_wraddr  = lsu_dccm_pkg::PIC_BASE | lsu_dccm_pkg::addr_t'(wr_offset);
   assign picm_wr_data = dma_pic_wen ? dma_wdata : store_data_r;

endmodule

// ==== rtl/load_data_merge.sv ====
// M-stage load merge and DMA return; one word per access, no cross-word spans
`timescale 1ns/1ps

module load_data_merge (
   input  logic                    clk,
   input  logic                    rst,
   lsu_stage_if.dst                stage_m,
   input  lsu_dccm_pkg::fdata_t    dccm_rd_data,
   input  lsu_dccm_pkg::data_t     sec_data_m,
   input  lsu_dccm_pkg::data_t     stbuf_fwddata_m,
   input  lsu_dccm_pkg::byteen_t   stbuf_fwdbyteen_m,
   input  lsu_dccm_pkg::data_t     picm_rd_data,
   input  logic                    double_ecc_error_m,
   input  lsu_dccm_pkg::dma_tag_t  dma_tag_m,
   output lsu_dccm_pkg::data_t     ld_data_m,
   output lsu_dccm_pkg::data_t     ld_data_r,
   output logic                    ld_valid_r,
   output logic                    dma_rvalid,
   output logic                    dma_ecc_error,
   output lsu_dccm_pkg::dma_tag_t  dma_rtag,
   output lsu_dccm_pkg::data_t     dma_rdata
);

   lsu_dccm_pkg::data_t raw_word;                           // merge over raw DCCM bits
   lsu_dccm_pkg::data_t corr_word;                          // merge over corrected bits
   lsu_dccm_pkg::data_t ld_corr_m;
   logic [4:0]          shamt;
   logic                ld_mem_m;

   always_comb begin
      for (int i = 0; i < lsu_dccm_pkg::BYTE_WIDTH; i++) begin
         if (stbuf_fwdbyteen_m[i]) begin
            raw_word[8*i +: 8]  = stbuf_fwddata_m[8*i +: 8];   // younger store wins
            corr_word[8*i +: 8] = stbuf_fwddata_m[8*i +: 8];
         end else if (stage_m.in_pic) begin
            raw_word[8*i +: 8]  = picm_rd_data[8*i +: 8];
            corr_word[8*i +: 8] = picm_rd_data[8*i +: 8];
         end else if (stage_m.in_dccm) begin
            raw_word[8*i +: 8]  = dccm_rd_data[8*i +: 8];
            corr_word[8*i +: 8] = sec_data_m[8*i +: 8];
         end else begin
            raw_word[8*i +: 8]  = 8'h00;
            corr_word[8*i +: 8] = 8'h00;
         end
      end
   end

   assign shamt     = {stage_m.addr[lsu_dccm_pkg::WIDTH_BITS-1:0], 3'b000};
   assign ld_data_m = raw_word >> shamt;                    // right justified, zero fill
   assign ld_corr_m = corr_word >> shamt;
   assign ld_mem_m  = stage_m.valid & stage_m.load & (stage_m.in_pic | stage_m.in_dccm);

   always_ff @(posedge clk) begin
      if (rst) begin
         ld_valid_r <= 1'b0;
      end else begin
         ld_valid_r <= ld_mem_m;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_mem_m) begin
         ld_data_r <= ld_corr_m;
      end
   end

   // DMA gets the whole corrected word back in M
   assign dma_rvalid    = stage_m.valid & stage_m.load & stage_m.dma;
   assign dma_ecc_error = double_ecc_error_m;
   assign dma_rtag      = dma_tag_m;
   assign dma_rdata     = corr_word;

endmodule

// ==== rtl/dccm_port_arb.sv ====
// DCCM read enable and single write port arbiter; write priority is ECC fix, DMA, store buffer
`timescale 1ns/1ps

module dccm_port_arb (
   lsu_stage_if.dst                 stage_d,
   ecc_wb_if.dst                    wb,
   input  logic                     dma_dccm_wen,
   input  logic                     stbuf_req,
   input  lsu_dccm_pkg::data_t      dma_wdata,
   input  lsu_dccm_pkg::ecc_t       dma_wecc,
   input  lsu_dccm_pkg::dccm_addr_t stbuf_addr,
   input  lsu_dccm_pkg::data_t      stbuf_data,
   input  lsu_dccm_pkg::ecc_t       stbuf_ecc,
   output logic                     stbuf_commit,
   output logic                     dccm_rden,
   output logic                     dccm_wren,
   output lsu_dccm_pkg::dccm_addr_t dccm_rd_addr,
   output lsu_dccm_pkg::dccm_addr_t dccm_wr_addr,
   output lsu_dccm_pkg::fdata_t     dccm_wr_data
);

   logic                store_rmw_d;                        // store needs old word for ECC
   logic                bank_hit;
   lsu_dccm_pkg::bank_t rd_bank;
   lsu_dccm_pkg::bank_t sb_bank;

   // an aligned word store rewrites every byte, so no read is needed
   assign store_rmw_d = stage_d.store &
                        ((stage_d.size != lsu_dccm_pkg::SIZE_WORD) |
                         (stage_d.addr[lsu_dccm_pkg::WIDTH_BITS-1:0] != '0));

   assign dccm_rden    = stage_d.valid & stage_d.in_dccm & (stage_d.load | store_rmw_d);
   assign dccm_rd_addr = stage_d.addr[lsu_dccm_pkg::DCCM_BITS-1:0];

   assign rd_bank  = stage_d.addr[lsu_dccm_pkg::WIDTH_BITS +: lsu_dccm_pkg::BANK_BITS];
   assign sb_bank  = stbuf_addr[lsu_dccm_pkg::WIDTH_BITS +: lsu_dccm_pkg::BANK_BITS];
   assign bank_hit = dccm_rden & (rd_bank == sb_bank);

   // commit may share the cycle with a read only when the banks differ
   assign stbuf_commit = stbuf_req & ~dma_dccm_wen & ~wb.pending & ~bank_hit;

   assign dccm_wren = wb.pending | dma_dccm_wen | stbuf_commit;

   always_comb begin
      if (wb.pending) begin
         dccm_wr_addr = wb.addr;
         dccm_wr_data = {wb.ecc, wb.data};
      end else if (dma_dccm_wen) begin
         dccm_wr_addr = stage_d.addr[lsu_dccm_pkg::DCCM_BITS-1:0];  // DMA writes from D
         dccm_wr_data = {dma_wecc, dma_wdata};
      end else begin
         dccm_wr_addr = stbuf_addr;
         dccm_wr_data = {stbuf_ecc, stbuf_data};
      end
   end

endmodule

// ==== rtl/ecc_corr_regs.sv ====
// single-bit ECC error capture in R; corrected word is written back one cycle later, once
`timescale 1ns/1ps

module ecc_corr_regs (
   input  logic               clk,
   input  logic               rst,
   lsu_stage_if.dst           stage_r,
   input  logic               commit_r,
   input  logic               single_ecc_error_r,
   input  logic               double_ecc_error_r,
   input  logic               raw_fwd_r,
   input  lsu_dccm_pkg::data_t sec_data_r,
   input  lsu_dccm_pkg::ecc_t  sec_ecc_r,
   output logic               ld_single_ecc_error_r,
   ecc_wb_if.src              wb
);

   logic wb_req_r;                                          // error worth fixing in memory

   // forwarded bytes did not come from memory, so a flag there means nothing
   assign ld_single_ecc_error_r = stage_r.valid & stage_r.load & single_ecc_error_r &
                                  ~raw_fwd_r & ~double_ecc_error_r;

   // speculative core loads that do not commit leave memory alone
   assign wb_req_r = ld_single_ecc_error_r & (commit_r | stage_r.dma);

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.pending <= 1'b0;
      end else begin
         wb.pending <= wb_req_r;                            // high for the one write cycle
      end
   end

   always_ff @(posedge clk) begin
      if (wb_req_r) begin
         wb.addr <= stage_r.addr[lsu_dccm_pkg::DCCM_BITS-1:0];
         wb.data <= sec_data_r;
         wb.ecc  <= sec_ecc_r;
      end
   end

endmodule

// ==== rtl/lsu_pipe_regs.sv ====
// D->M->R packet pipeline with region decode in D; never stalls, only valids are reset
`timescale 1ns/1ps

module lsu_pipe_regs (
   input  logic                clk,
   input  logic                rst,
   input  logic                d_valid,
   input  logic                d_load,
   input  logic                d_store,
   input  logic                d_dma,
   input  lsu_dccm_pkg::size_t d_size,
   input  lsu_dccm_pkg::addr_t d_addr,
   input  lsu_dccm_pkg::data_t store_data_m,
   output lsu_dccm_pkg::data_t store_data_r,
   lsu_stage_if.src            stage_d,
   lsu_stage_if.src            stage_m,
   lsu_stage_if.src            stage_r
);

   assign stage_d.valid = d_valid;
   assign stage_d.load  = d_load;
   assign stage_d.store = d_store;
   assign stage_d.dma   = d_dma;
   assign stage_d.size  = d_size;
   assign stage_d.addr  = d_addr;

   // region match on the bits above each window's offset
   assign stage_d.in_dccm = d_addr[lsu_dccm_pkg::DCCM_BITS +: lsu_dccm_pkg::DCCM_REGION_BITS] ==
                            lsu_dccm_pkg::DCCM_BASE[31:lsu_dccm_pkg::DCCM_BITS];
   assign stage_d.in_pic  = d_addr[31:lsu_dccm_pkg::PIC_BITS] ==
                            lsu_dccm_pkg::PIC_BASE[31:lsu_dccm_pkg::PIC_BITS];

   always_ff @(posedge clk) begin
      if (rst) begin
         stage_m.valid <= 1'b0;
         stage_r.valid <= 1'b0;
      end else begin
         stage_m.valid <= stage_d.valid;
         stage_r.valid <= stage_m.valid;
      end
   end

   // packet payload follows its valid one stage at a time
   always_ff @(posedge clk) begin
      stage_m.load    <= stage_d.load;
      stage_m.store   <= stage_d.store;
      stage_m.dma     <= stage_d.dma;
      stage_m.size    <= stage_d.size;
      stage_m.addr    <= stage_d.addr;
      stage_m.in_dccm <= stage_d.in_dccm;
      stage_m.in_pic  <= stage_d.in_pic;
      stage_r.load    <= stage_m.load;
      stage_r.store   <= stage_m.store;
      stage_r.dma     <= stage_m.dma;
      stage_r.size    <= stage_m.size;
      stage_r.addr    <= stage_m.addr;
      stage_r.in_dccm <= stage_m.in_dccm;
      stage_r.in_pic  <= stage_m.in_pic;
      store_data_r    <= store_data_m;                      // store data joins in M
   end

endmodule

// ==== rtl/lsu_stage_if.sv ====
// stage packet and ECC write-back bundles; both are driven by exactly one module each
`timescale 1ns/1ps

interface lsu_stage_if;
   logic                valid;
   logic                load;
   logic                store;
   logic                dma;
   lsu_dccm_pkg::size_t size;
   lsu_dccm_pkg::addr_t addr;
   logic                in_dccm;                            // decoded in D, carried down
   logic                in_pic;

   modport src (output valid, load, store, dma, size, addr, in_dccm, in_pic);
   modport dst (input  valid, load, store, dma, size, addr, in_dccm, in_pic);
endinterface

interface ecc_wb_if;
   logic                     pending;                       // write-back due this cycle
   lsu_dccm_pkg::dccm_addr_t addr;
   lsu_dccm_pkg::data_t      data;
   lsu_dccm_pkg::ecc_t       ecc;

   modport src (output pending, addr, data, ecc);
   modport dst (input  pending, addr, data, ecc);
endinterface

// ==== rtl/lsu_dccm_pkg.sv ====
// shared widths, address map and types; single-word DCCM accesses only, no unaligned spans
package lsu_dccm_pkg;

   localparam int DCCM_BITS        = 12;                    // 4 KiB of DCCM
   localparam int DCCM_REGION_BITS = 32 - DCCM_BITS;        // region tag above the offset
   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;

   localparam int PIC_BITS = 15;                            // PIC register offset bits
   localparam logic [31:0] PIC_BASE = 32'hF00C_0000;

   localparam int DATA_WIDTH  = 32;
   localparam int ECC_WIDTH   = 7;
   localparam int FDATA_WIDTH = DATA_WIDTH + ECC_WIDTH;     // check bits sit on top

   localparam int BYTE_WIDTH = 4;                           // bytes per word
   localparam int WIDTH_BITS = 2;                           // byte offset within a word
   localparam int BANK_BITS  = 2;                           // bank select above the offset

   typedef logic [31:0]               addr_t;
   typedef logic [DCCM_BITS-1:0]      dccm_addr_t;
   typedef logic [DATA_WIDTH-1:0]     data_t;
   typedef logic [ECC_WIDTH-1:0]      ecc_t;
   typedef logic [FDATA_WIDTH-1:0]    fdata_t;
   typedef logic [BYTE_WIDTH-1:0]     byteen_t;
   typedef logic [1:0]                size_t;
   typedef logic [2:0]                dma_tag_t;
   typedef logic [BANK_BITS-1:0]      bank_t;

   // access size codes
   localparam size_t SIZE_BYTE = 2'b00;
   localparam size_t SIZE_HALF = 2'b01;
   localparam size_t SIZE_WORD = 2'b10;

endpackage
